//--- include/forth_defines.svh
`ifndef FORTH_DEFINES_SVH
`define FORTH_DEFINES_SVH

// data word, RAM word and instruction width
`define FORTH_WORD 16

// program ROM and data RAM address widths
`define ROM_BITS 8
`define RAM_BITS 8

// region select is addr[MEM_SEL_LSB+2:MEM_SEL_LSB]
`define MEM_SEL_LSB 9

`define STACK_DEPTH 8

// clk cycles per timer tick
`define TIMER_PRESCALE 4

`endif

//--- hdl/forth_pkg.sv
`include "forth_defines.svh"

package forth_pkg;

    typedef enum logic [3:0] {
        OP_LIT   = 4'd0,
        OP_ADD   = 4'd1,
        OP_SUB   = 4'd2,
        OP_AND   = 4'd3,
        OP_XOR   = 4'd4,
        OP_DUP   = 4'd5,
        OP_DROP  = 4'd6,
        OP_SWAP  = 4'd7,
        OP_FETCH = 4'd8,
        OP_STORE = 4'd9,
        OP_JZ    = 4'd10,
        OP_JMP   = 4'd11,
        OP_WFI   = 4'd12,
        OP_HLT   = 4'd13
    } opcode_e;

    typedef enum logic [2:0] {
        S_FETCH,
        S_EXECUTE,
        S_MEMORY,
        S_WAIT,
        S_HALT,
        S_ERROR
    } cpu_state_e;

    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [`FORTH_WORD-1:0] addr;
        logic [`FORTH_WORD-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                   ready;
        logic                   error;
        logic [`FORTH_WORD-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic                   en;
        logic [`ROM_BITS-1:0]   addr;
        logic [`FORTH_WORD-1:0] data;
    } rom_write_t;

endpackage

//--- hdl/data_stack.sv
`timescale 1ns/1ps
`include "forth_defines.svh"

module data_stack (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  logic                   pop,
    input  logic                   replace_top,
    input  logic [`FORTH_WORD-1:0] push_data,
    output logic [`FORTH_WORD-1:0] top,
    output logic [`FORTH_WORD-1:0] second,
    output logic                   overflow,
    output logic                   underflow
);
    localparam int PTR_W = $clog2(`STACK_DEPTH + 1);
    localparam int IDX_W = $clog2(`STACK_DEPTH);

    logic [`FORTH_WORD-1:0] mem [0:`STACK_DEPTH-1];
    // number of valid entries
    logic [PTR_W-1:0] sp;
    logic [PTR_W-1:0] needed;
    logic [IDX_W-1:0] push_idx;
    logic [IDX_W-1:0] top_idx;
    logic [IDX_W-1:0] second_idx;
    logic             op_ok;

    assign push_idx   = sp[IDX_W-1:0];
    assign top_idx    = IDX_W'(sp - 1'b1);
    assign second_idx = IDX_W'(sp - 2'd2);
    assign top        = mem[top_idx];
    assign second     = mem[second_idx];

    // replace_top needs the top as an operand and pop needs one more
    assign needed    = PTR_W'(replace_top) + PTR_W'(pop);
    assign underflow = sp < needed;
    assign overflow  = push && !pop && (sp == PTR_W'(`STACK_DEPTH));
    assign op_ok     = !overflow && !underflow;

    always_ff @(posedge clk) begin
        if (op_ok) begin
            if (push && pop) begin
                // swap puts push_data on top and moves the old top down
                mem[top_idx]    <= push_data;
                mem[second_idx] <= top;
            end else if (push) begin
                mem[push_idx] <= push_data;
            end else if (pop && replace_top) begin
                mem[second_idx] <= push_data;
            end else if (replace_top) begin
                mem[top_idx] <= push_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sp <= '0;
        end else if (op_ok) begin
            if (push && !pop) begin
                sp <= sp + 1'b1;
            end else if (pop && !push) begin
                sp <= sp - 1'b1;
            end
        end
    end

    a_push_pop_combined: assert property (@(posedge clk) disable iff (reset)
        !(push && pop && !replace_top));

endmodule

//--- hdl/forth_cpu.sv
`timescale 1ns/1ps
`include "forth_defines.svh"

module forth_cpu (
    input  logic                  clk,
    input  logic                  reset,
    input  forth_pkg::rom_write_t rom_load,
    input  forth_pkg::mem_rsp_t   mem_rsp,
    input  logic                  interrupt,
    output forth_pkg::mem_req_t   mem_req,
    output logic                  interrupt_ack,
    output logic                  error,
    output logic                  hlt,
    output logic                  wfi
);
    import forth_pkg::*;

    logic [`FORTH_WORD-1:0] rom [0:(1<<`ROM_BITS)-1];
    logic [`FORTH_WORD-1:0] instr;
    logic [`ROM_BITS-1:0]   pc;
    cpu_state_e             state;
    opcode_e                opcode;
    logic [11:0]            imm;
    logic [`FORTH_WORD-1:0] imm_word;
    logic [`FORTH_WORD-1:0] alu_result;

    logic                   push;
    logic                   pop;
    logic                   replace_top;
    logic [`FORTH_WORD-1:0] push_data;
    logic [`FORTH_WORD-1:0] top;
    logic [`FORTH_WORD-1:0] second;
    logic                   overflow;
    logic                   underflow;

    assign opcode   = opcode_e'(instr[15:12]);
    assign imm      = instr[11:0];
    assign imm_word = {{(`FORTH_WORD-12){1'b0}}, imm};

    assign error = (state == S_ERROR);
    assign hlt   = (state == S_HALT);
    assign wfi   = (state == S_WAIT);

    data_stack data_stack_i (
        .clk         (clk),
        .reset       (reset),
        .push        (push),
        .pop         (pop),
        .replace_top (replace_top),
        .push_data   (push_data),
        .top         (top),
        .second      (second),
        .overflow    (overflow),
        .underflow   (underflow)
    );

    // program ROM written by the host while reset is held
    always_ff @(posedge clk) begin
        if (rom_load.en) begin
            rom[rom_load.addr] <= rom_load.data;
        end
        if (state == S_FETCH) begin
            instr <= rom[pc];
        end
    end

    // a is second, b is top
    always_comb begin
        case (opcode)
            OP_ADD:  alu_result = second + top;
            OP_SUB:  alu_result = second - top;
            OP_AND:  alu_result = second & top;
            default: alu_result = second ^ top;
        endcase
    end

    always_comb begin
        push        = 1'b0;
        pop         = 1'b0;
        replace_top = 1'b0;
        push_data   = top;
        if (state == S_EXECUTE) begin
            case (opcode)
                OP_LIT: begin
                    push      = 1'b1;
                    push_data = imm_word;
                end
                OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                    pop         = 1'b1;
                    replace_top = 1'b1;
                    push_data   = alu_result;
                end
                OP_DUP: begin
                    push        = 1'b1;
                    replace_top = 1'b1;
                end
                OP_DROP, OP_JZ: pop = 1'b1;
                OP_SWAP: begin
                    push        = 1'b1;
                    pop         = 1'b1;
                    replace_top = 1'b1;
                    push_data   = second;
                end
                // top rewritten with itself to check the address exists
                OP_FETCH: replace_top = 1'b1;
                // drop the address and rewrite the data in place to check depth 2
                OP_STORE: begin
                    pop         = 1'b1;
                    replace_top = 1'b1;
                    push_data   = second;
                end
                default: ;
            endcase
        end else if (state == S_MEMORY && mem_rsp.ready && !mem_rsp.error) begin
            if (mem_req.write) begin
                pop = 1'b1;
            end else begin
                replace_top = 1'b1;
                push_data   = mem_rsp.rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= S_FETCH;
            pc            <= '0;
            mem_req       <= '0;
            interrupt_ack <= 1'b0;
        end else begin
            interrupt_ack <= 1'b0;
            case (state)
                S_FETCH: state <= S_EXECUTE;
                S_EXECUTE: begin
                    pc    <= pc + 1'b1;
                    state <= S_FETCH;
                    if (overflow || underflow) begin
                        state <= S_ERROR;
                    end else begin
                        case (opcode)
                            OP_JZ: begin
                                if (top == '0) begin
                                    pc <= imm[`ROM_BITS-1:0];
                                end
                            end
                            OP_JMP: pc <= imm[`ROM_BITS-1:0];
                            OP_FETCH: begin
                                mem_req <= '{valid: 1'b1, write: 1'b0, addr: top, wdata: '0};
                                state   <= S_MEMORY;
                            end
                            OP_STORE: begin
                                mem_req <= '{valid: 1'b1, write: 1'b1, addr: top, wdata: second};
                                state   <= S_MEMORY;
                            end
                            OP_WFI: state <= S_WAIT;
                            OP_HLT: state <= S_HALT;
                            OP_LIT, OP_ADD, OP_SUB, OP_AND, OP_XOR,
                            OP_DUP, OP_DROP, OP_SWAP: ;
                            // codes 14 and 15
                            default: state <= S_ERROR;
                        endcase
                    end
                end
                S_MEMORY: begin
                    if (mem_rsp.ready) begin
                        mem_req.valid <= 1'b0;
                        state         <= mem_rsp.error ? S_ERROR : S_FETCH;
                    end
                end
                S_WAIT: begin
                    if (interrupt) begin
                        interrupt_ack <= 1'b1;
                        state         <= S_FETCH;
                    end
                end
                S_HALT, S_ERROR: ;
                default: state <= S_ERROR;
            endcase
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (reset)
        (mem_req.valid && !mem_rsp.ready) |=> $stable(mem_req));

endmodule

//--- hdl/interval_timer.sv
`timescale 1ns/1ps
`include "forth_defines.svh"

module interval_timer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   timer_load,
    input  logic [`FORTH_WORD-1:0] load_value,
    input  logic                   interrupt_ack,
    output logic                   interrupt
);
    localparam int PRE_W = (`TIMER_PRESCALE > 1) ? $clog2(`TIMER_PRESCALE) : 1;

    logic [PRE_W-1:0]       prescale;
    logic [`FORTH_WORD-1:0] count;
    logic                   armed;
    logic                   tick;

    assign tick = armed && (prescale == PRE_W'(`TIMER_PRESCALE - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            prescale  <= '0;
            count     <= '0;
            armed     <= 1'b0;
            interrupt <= 1'b0;
        end else begin
            if (interrupt_ack) begin
                interrupt <= 1'b0;
            end
            if (timer_load) begin
                // zero disarms
                count    <= load_value;
                armed    <= (load_value != '0);
                prescale <= '0;
            end else if (armed) begin
                prescale <= tick ? '0 : prescale + 1'b1;
                if (tick) begin
                    count <= count - 1'b1;
                    if (count == 1) begin
                        armed     <= 1'b0;
                        interrupt <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- hdl/memory_bus.sv
`timescale 1ns/1ps
`include "forth_defines.svh"

module memory_bus (
    input  logic                   clk,
    input  logic                   reset,
    input  forth_pkg::mem_req_t    mem_req,
    output forth_pkg::mem_rsp_t    mem_rsp,
    output logic                   timer_load,
    output logic [`FORTH_WORD-1:0] timer_value,
    output logic [`FORTH_WORD-1:0] port_out,
    output logic                   port_valid
);
    localparam logic [2:0] REGION_RAM   = 3'd0;
    localparam logic [2:0] REGION_TIMER = 3'd4;
    localparam logic [2:0] REGION_PORT  = 3'd7;

    logic [`FORTH_WORD-1:0] ram [0:(1<<`RAM_BITS)-1];
    logic [2:0]             region;
    logic [`RAM_BITS-1:0]   ram_addr;
    logic                   accept;
    logic                   mapped;
    logic                   ready_q;
    logic                   error_q;
    logic [`FORTH_WORD-1:0] rdata_q;

    assign region   = mem_req.addr[`MEM_SEL_LSB+2:`MEM_SEL_LSB];
    assign ram_addr = mem_req.addr[`RAM_BITS-1:0];
    assign mapped   = (region == REGION_RAM) || (region == REGION_TIMER) ||
                      (region == REGION_PORT);
    // only the first cycle of a request is taken, not the held cycle after ready
    assign accept   = mem_req.valid && !ready_q;
    assign mem_rsp  = '{ready: ready_q, error: error_q, rdata: rdata_q};

    // read before write on the same address
    always_ff @(posedge clk) begin
        if (accept) begin
            if (region == REGION_RAM && mem_req.write) begin
                ram[ram_addr] <= mem_req.wdata;
            end
            rdata_q <= (region == REGION_RAM) ? ram[ram_addr] : '0;
            if (region == REGION_TIMER && mem_req.write) begin
                timer_value <= mem_req.wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q    <= 1'b0;
            error_q    <= 1'b0;
            timer_load <= 1'b0;
            port_valid <= 1'b0;
            port_out   <= '0;
        end else begin
            ready_q    <= accept;
            error_q    <= accept && !mapped;
            timer_load <= accept && mem_req.write && (region == REGION_TIMER);
            port_valid <= accept && mem_req.write && (region == REGION_PORT);
            if (accept && mem_req.write && region == REGION_PORT) begin
                port_out <= mem_req.wdata;
            end
        end
    end

    // the master still holds its request when ready comes back
    a_valid_held_to_ready: assert property (@(posedge clk) disable iff (reset)
        mem_rsp.ready |-> mem_req.valid);

endmodule

//--- hdl/forth_system.sv
`timescale 1ns/1ps
`include "forth_defines.svh"

module forth_system (
    input  logic                   clk,
    input  logic                   reset,
    input  forth_pkg::rom_write_t  rom_load,
    output logic [`FORTH_WORD-1:0] port_out,
    output logic                   port_valid,
    output logic                   error,
    output logic                   hlt,
    output logic                   wfi
);
    import forth_pkg::*;

    mem_req_t               mem_req;
    mem_rsp_t               mem_rsp;
    logic                   timer_load;
    logic [`FORTH_WORD-1:0] timer_value;
    logic                   interrupt;
    logic                   interrupt_ack;

    forth_cpu forth_cpu_i (
        .clk           (clk),
        .reset         (reset),
        .rom_load      (rom_load),
        .mem_rsp       (mem_rsp),
        .interrupt     (interrupt),
        .mem_req       (mem_req),
        .interrupt_ack (interrupt_ack),
        .error         (error),
        .hlt           (hlt),
        .wfi           (wfi)
    );

    memory_bus memory_bus_i (
        .clk         (clk),
        .reset       (reset),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .timer_load  (timer_load),
        .timer_value (timer_value),
        .port_out    (port_out),
        .port_valid  (port_valid)
    );

    interval_timer interval_timer_i (
        .clk           (clk),
        .reset         (reset),
        .timer_load    (timer_load),
        .load_value    (timer_value),
        .interrupt_ack (interrupt_ack),
        .interrupt     (interrupt)
    );

endmodule

//--- testbench/tb_forth_system.sv
`timescale 1ns/1ps
`include "forth_defines.svh"

module tb_forth_system;
    import forth_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_PROGS    = 12;
    localparam int BLOCKS       = 8;
    localparam int MAX_LEN      = 128;
    // worst case per instruction includes a WFI on a timer load of 8
    localparam int CYCLE_BOUND  = 64;
    localparam longint WATCHDOG_NS = longint'(NUM_PROGS) * MAX_LEN * CYCLE_BOUND * CLK_PERIOD;

    localparam logic [2:0]  RAM_REGION   = 3'd0;
    localparam logic [2:0]  TIMER_REGION = 3'd4;
    localparam logic [2:0]  PORT_REGION  = 3'd7;
    localparam logic [15:0] TIMER_ADDR   = 16'(TIMER_REGION) << `MEM_SEL_LSB;
    localparam logic [15:0] PORT_ADDR    = 16'(PORT_REGION) << `MEM_SEL_LSB;

    logic                   clk;
    logic                   reset;
    rom_write_t             rom_load;
    logic [`FORTH_WORD-1:0] port_out;
    logic                   port_valid;
    logic                   error;
    logic                   hlt;
    logic                   wfi;

    logic [15:0] lfsr_state;
    logic [15:0] prog [0:(1<<`ROM_BITS)-1];
    int          plen;
    logic [15:0] ram_model [0:(1<<`RAM_BITS)-1];
    logic [15:0] exp_port [$];
    bit          exp_error;
    bit          exp_hlt;
    bit          exp_wfi;
    int          mismatch_count;
    int          failure_count;
    int          port_writes;

    forth_system forth_system_i (
        .clk        (clk),
        .reset      (reset),
        .rom_load   (rom_load),
        .port_out   (port_out),
        .port_valid (port_valid),
        .error      (error),
        .hlt        (hlt),
        .wfi        (wfi)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all programs finished");
        $display("Simulation failed");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[14:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic opcode_e alu_op(input logic [1:0] sel);
        case (sel)
            2'd0:    return OP_ADD;
            2'd1:    return OP_SUB;
            2'd2:    return OP_AND;
            default: return OP_XOR;
        endcase
    endfunction

    function automatic logic [15:0] alu_model(input opcode_e op, input logic [15:0] a,
                                              input logic [15:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            default: return a ^ b;
        endcase
    endfunction

    function automatic bit is_mapped(input logic [2:0] region);
        return region == RAM_REGION || region == TIMER_REGION || region == PORT_REGION;
    endfunction

    task automatic emit(input opcode_e op, input logic [15:0] value);
        prog[plen] = {op, value[11:0]};
        plen++;
    endtask

    task automatic emit_port_store();
        emit(OP_LIT, PORT_ADDR);
        emit(OP_STORE, 16'd0);
    endtask

    task automatic emit_arith_block();
        logic [15:0] r;
        r = take_bits(8);
        emit(OP_LIT, take_bits(12));
        emit(OP_LIT, take_bits(12));
        if (r[0]) emit(OP_SWAP, 16'd0);
        emit(alu_op(r[2:1]), 16'd0);
        if (r[3]) begin
            emit(OP_DUP, 16'd0);
            emit(alu_op(r[7:6]), 16'd0);
        end
        if (r[4]) begin
            emit(OP_LIT, take_bits(12));
            if (r[5]) emit(OP_SWAP, 16'd0);
            emit(OP_DROP, 16'd0);
        end
        emit_port_store();
    endtask

    task automatic emit_ram_block();
        logic [15:0] wr_addr;
        logic [15:0] rd_addr;
        // bit 8 lies outside the RAM index and aliases
        wr_addr = (take_bits(1) << 8) | take_bits(2);
        rd_addr = take_bits(1) ? wr_addr : ((take_bits(1) << 8) | take_bits(2));
        emit(OP_LIT, take_bits(12));
        emit(OP_LIT, wr_addr);
        emit(OP_STORE, 16'd0);
        emit(OP_LIT, rd_addr);
        emit(OP_FETCH, 16'd0);
        emit_port_store();
    endtask

    task automatic emit_wfi_block();
        emit(OP_LIT, 16'd1 + take_bits(3));
        emit(OP_LIT, TIMER_ADDR);
        emit(OP_STORE, 16'd0);
        emit(OP_WFI, 16'd0);
        emit(OP_LIT, take_bits(12));
        emit_port_store();
    endtask

    task automatic emit_plain_block();
        logic [15:0] sel;
        sel = take_bits(2);
        case (sel[1:0])
            2'd0, 2'd1: emit_arith_block();
            2'd2:       emit_ram_block();
            default:    emit_wfi_block();
        endcase
    endtask

    // forward branch around one plain block
    task automatic emit_branch_block();
        logic [15:0] r;
        int          patch_at;
        r = take_bits(2);
        if (r[0]) begin
            emit(OP_LIT, r[1] ? take_bits(12) : 16'd0);
            patch_at = plen;
            emit(OP_JZ, 16'd0);
        end else begin
            patch_at = plen;
            emit(OP_JMP, 16'd0);
        end
        emit_plain_block();
        prog[patch_at][11:0] = 12'(plen);
    endtask

    task automatic emit_fault_block();
        logic [15:0] r;
        logic [15:0] w;
        logic [2:0]  region;
        r = take_bits(2);
        region = 3'(take_bits(2)) + 3'd1;
        if (region == TIMER_REGION) region = 3'd6;
        case (r[1:0])
            2'd0: begin
                // one item on the stack where ADD needs two
                emit(OP_LIT, take_bits(12));
                emit(OP_ADD, 16'd0);
            end
            2'd1: begin
                w = take_bits(13);
                prog[plen] = {3'b111, w[12:0]};
                plen++;
            end
            2'd2: begin
                emit(OP_LIT, take_bits(12));
                emit(OP_LIT, 16'(region) << `MEM_SEL_LSB);
                emit(OP_STORE, 16'd0);
            end
            default: begin
                emit(OP_LIT, 16'(region) << `MEM_SEL_LSB);
                emit(OP_FETCH, 16'd0);
            end
        endcase
    endtask

    task automatic build_program(input bit with_fault);
        logic [15:0] sel;
        int          fault_at;
        plen = 0;
        // RAM words 0 to 3 get known contents before any fetch
        for (int a = 0; a < 4; a++) begin
            emit(OP_LIT, take_bits(12));
            emit(OP_LIT, 16'(a));
            emit(OP_STORE, 16'd0);
        end
        fault_at = int'(take_bits(3));
        for (int b = 0; b < BLOCKS; b++) begin
            if (with_fault && b == fault_at) emit_fault_block();
            sel = take_bits(2);
            if (sel == 16'd0) begin
                emit_branch_block();
            end else begin
                emit_plain_block();
            end
        end
        emit(OP_HLT, 16'd0);
    endtask

    // ISA reference model
    task automatic run_model();
        logic [15:0] stk [0:`STACK_DEPTH-1];
        logic [15:0] ins;
        logic [15:0] addr;
        logic [15:0] tmp;
        logic [2:0]  region;
        int          depth;
        int          need;
        int          pc;
        bit          grows;
        bit          running;
        exp_port.delete();
        exp_error = 1'b0;
        exp_hlt = 1'b0;
        exp_wfi = 1'b0;
        depth = 0;
        pc = 0;
        running = 1'b1;
        while (running) begin
            ins = prog[pc];
            pc = pc + 1;
            case (opcode_e'(ins[15:12]))
                OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_SWAP, OP_STORE: need = 2;
                OP_DUP, OP_DROP, OP_FETCH, OP_JZ: need = 1;
                default: need = 0;
            endcase
            grows = (ins[15:12] == OP_LIT) || (ins[15:12] == OP_DUP);
            if (depth < need || (grows && depth == `STACK_DEPTH)) begin
                exp_error = 1'b1;
                running = 1'b0;
            end else begin
                case (opcode_e'(ins[15:12]))
                    OP_LIT: begin
                        stk[depth] = {4'b0, ins[11:0]};
                        depth++;
                    end
                    OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                        depth--;
                        stk[depth-1] = alu_model(opcode_e'(ins[15:12]), stk[depth-1],
                                                 stk[depth]);
                    end
                    OP_DUP: begin
                        stk[depth] = stk[depth-1];
                        depth++;
                    end
                    OP_DROP: depth--;
                    OP_SWAP: begin
                        tmp = stk[depth-1];
                        stk[depth-1] = stk[depth-2];
                        stk[depth-2] = tmp;
                    end
                    OP_FETCH: begin
                        addr = stk[depth-1];
                        region = addr[`MEM_SEL_LSB+2:`MEM_SEL_LSB];
                        if (!is_mapped(region)) begin
                            exp_error = 1'b1;
                            running = 1'b0;
                        end else begin
                            stk[depth-1] = (region == RAM_REGION) ?
                                           ram_model[addr[`RAM_BITS-1:0]] : 16'd0;
                        end
                    end
                    OP_STORE: begin
                        addr = stk[depth-1];
                        tmp = stk[depth-2];
                        depth -= 2;
                        region = addr[`MEM_SEL_LSB+2:`MEM_SEL_LSB];
                        if (!is_mapped(region)) begin
                            exp_error = 1'b1;
                            running = 1'b0;
                        end else if (region == RAM_REGION) begin
                            ram_model[addr[`RAM_BITS-1:0]] = tmp;
                        end else if (region == PORT_REGION) begin
                            exp_port.push_back(tmp);
                        end
                    end
                    OP_JZ: begin
                        depth--;
                        if (stk[depth] == 16'd0) pc = int'(ins[`ROM_BITS-1:0]);
                    end
                    OP_JMP: pc = int'(ins[`ROM_BITS-1:0]);
                    OP_WFI: exp_wfi = 1'b1;
                    OP_HLT: begin
                        exp_hlt = 1'b1;
                        running = 1'b0;
                    end
                    default: begin
                        exp_error = 1'b1;
                        running = 1'b0;
                    end
                endcase
            end
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        assert (actual === expected) else begin
            mismatch_count++;
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, expected,
                     actual);
        end
    endtask

    task automatic check_idle();
        check_value("hlt", 16'(hlt), 16'd0);
        check_value("error", 16'(error), 16'd0);
        check_value("wfi", 16'(wfi), 16'd0);
        check_value("port_valid", 16'(port_valid), 16'd0);
        check_value("port_out", port_out, 16'd0);
    endtask

    task automatic load_and_reset();
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < plen; i++) begin
            @(posedge clk);
            rom_load <= '{en: 1'b1, addr: i[`ROM_BITS-1:0], data: prog[i]};
        end
        @(posedge clk);
        rom_load <= '0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_idle();
        @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic run_program(input int prog_idx);
        bit done;
        bit wfi_seen;
        done = 1'b0;
        wfi_seen = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (port_valid) begin
                assert (exp_port.size() > 0) else begin
                    failure_count++;
                    $display("Program %0d wrote %h to the port after the last expected write",
                             prog_idx, port_out);
                end
                if (exp_port.size() > 0) begin
                    check_value("port_out", port_out, exp_port.pop_front());
                    port_writes++;
                end
            end
            if (wfi) wfi_seen = 1'b1;
            done = hlt || error;
        end
        // status must hold until the next reset
        repeat (4) @(negedge clk);
        check_value("error", 16'(error), 16'(exp_error));
        check_value("hlt", 16'(hlt), 16'(exp_hlt));
        assert (exp_port.size() == 0) else begin
            failure_count++;
            $display("Program %0d stopped with %0d port writes still missing", prog_idx,
                     exp_port.size());
        end
        assert (!exp_wfi || wfi_seen) else begin
            failure_count++;
            $display("Program %0d executed WFI but wfi was never seen high", prog_idx);
        end
    endtask

    initial begin
        reset = 1'b1;
        rom_load = '0;
        lfsr_state = 16'd69;
        mismatch_count = 0;
        failure_count = 0;
        port_writes = 0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            // every third program carries a fault
            build_program(p % 3 == 2);
            run_model();
            load_and_reset();
            run_program(p);
        end
        $display("%0d programs, %0d port writes checked, %0d mismatches, %0d other failures",
                 NUM_PROGS, port_writes, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+include
hdl/forth_pkg.sv
hdl/data_stack.sv
hdl/forth_cpu.sv
hdl/interval_timer.sv
hdl/memory_bus.sv
hdl/forth_system.sv
testbench/tb_forth_system.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_forth_system -f list.f -o sim_forth_system
./obj_dir/sim_forth_system | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
echo "run passed"
